//--- verilog/dw_macros.svh
/*
 * Global size macros for the AXI4-Lite downsizer.
 * Address width, slave and master data and strobe widths,
 * the downsize factor and the beat select position and width.
 */
`ifndef DW_MACROS_SVH
`define DW_MACROS_SVH

// Address width shared by both ports.
`define DW_ADDR_WIDTH 16

// Data width of the wide slave port.
`define DW_SLV_DATA_WIDTH 64

// Data width of the narrow master port.
`define DW_MST_DATA_WIDTH 32

// One strobe bit per data byte on each port.
`define DW_SLV_STRB_WIDTH 8
`define DW_MST_STRB_WIDTH 4

// Number of narrow beats that make up one wide transaction.
`define DW_FACTOR 2

// Width of the beat counter, log2 of the downsize factor.
`define DW_SEL_WIDTH 1

// Lowest address bit of the beat select, log2 of the master strobe width.
`define DW_SEL_OFFSET 2

`endif

//--- verilog/dw_chan_pkg.sv
/*
 * Channel payload types of the downsizer.
 * Address, data and strobe types for both ports,
 * plus the AW and AR request channel structs.
 */
`include "dw_macros.svh"

package dw_chan_pkg;

  // Byte address, identical on both ports.
  typedef logic [`DW_ADDR_WIDTH-1:0] addr_t;

  // Wide data and strobe as seen on the slave port.
  typedef logic [`DW_SLV_DATA_WIDTH-1:0] slv_data_t;
  typedef logic [`DW_SLV_STRB_WIDTH-1:0] slv_strb_t;

  // Narrow data and strobe as driven on the master port.
  typedef logic [`DW_MST_DATA_WIDTH-1:0] mst_data_t;
  typedef logic [`DW_MST_STRB_WIDTH-1:0] mst_strb_t;

  // AXI protection attributes.
  typedef logic [2:0] prot_t;

  // Write address channel payload.
  // The address sits in the upper bits and the protection in the lower bits.
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_chan_t;

  // Read address channel payload.
  // It has the same layout as AW but is kept as its own type so that
  // the two request channels cannot be swapped by mistake.
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

endpackage

//--- verilog/dw_resp_pkg.sv
/*
 * Response types of the downsizer.
 * AXI response code with its four named values and the beat select type.
 */
`include "dw_macros.svh"

package dw_resp_pkg;

  // AXI response code, shared by B and R.
  typedef logic [1:0] resp_t;

  // The encodings are chosen by AXI so that an OR of two codes
  // never reports less severity than either input.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_EXOKAY = 2'b01;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // Counts the narrow beats within one wide transaction.
  typedef logic [`DW_SEL_WIDTH-1:0] beat_sel_t;

endpackage

//--- verilog/dw_addr_splitter.sv
/*
 * Address splitter for the downsizer.
 * Holds one AW or AR request and issues one aligned master
 * address per narrow beat, lower beat first.
 */
`timescale 1ns/10ps
`include "dw_macros.svh"

module dw_addr_splitter #(
  parameter type chan_t = dw_chan_pkg::aw_chan_t
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  chan_t chan_i,
  input  logic  valid_i,
  output logic  ready_o,
  output chan_t chan_o,
  output logic  valid_o,
  input  logic  ready_i
);

  // One-entry request buffer and its occupancy flag.
  chan_t buf_q;
  logic  full_q;

  // Index of the narrow beat currently offered on the master side.
  dw_resp_pkg::beat_sel_t sel_q;

  logic beat_xfer;
  logic last_beat;
  logic take;

  // A narrow beat leaves on every master handshake.
  assign beat_xfer = valid_o & ready_i;
  assign last_beat = (sel_q == dw_resp_pkg::beat_sel_t'(`DW_FACTOR - 1));

  // The buffer accepts when empty, or when its final beat leaves in this
  // same cycle, so back-to-back requests lose no cycle.
  assign ready_o = ~full_q | (beat_xfer & last_beat);
  assign take    = valid_i & ready_o;

  // Master valid is simply the occupancy of the buffer.
  assign valid_o = full_q;

  // The beat counter replaces the select bits of the address.
  // Bits below the select are cleared so that every beat is word aligned.
  always_comb begin
    chan_o = buf_q;
    chan_o.addr[`DW_SEL_OFFSET +: `DW_SEL_WIDTH] = sel_q;
    chan_o.addr[`DW_SEL_OFFSET-1:0] = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      // A new request wins over the release of the old one.
      if (take) begin
        full_q <= 1'b1;
      end else if (beat_xfer && last_beat) begin
        full_q <= 1'b0;
      end
      // The counter wraps to zero after the last beat.
      if (beat_xfer) begin
        sel_q <= dw_resp_pkg::beat_sel_t'(sel_q + 1'b1);
      end
    end
  end

  // Request payload.
  always_ff @(posedge clk_i) begin
    if (take) begin
      buf_q <= chan_i;
    end
  end

  // A stalled master request keeps both its payload and its beat address.
  a_chan_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(chan_o)))
    else $error("Master address changed while stalled.");

endmodule

//--- verilog/dw_wdata_slicer.sv
/*
 * Write data slicer for the downsizer.
 * Holds one wide W beat and sends its data and strobe halves
 * on the narrow master W channel, lower half first.
 */
`timescale 1ns/10ps
`include "dw_macros.svh"

module dw_wdata_slicer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  dw_chan_pkg::slv_data_t slv_data_i,
  input  dw_chan_pkg::slv_strb_t slv_strb_i,
  input  logic                  slv_valid_i,
  output logic                  slv_ready_o,
  output dw_chan_pkg::mst_data_t mst_data_o,
  output dw_chan_pkg::mst_strb_t mst_strb_o,
  output logic                  mst_valid_o,
  input  logic                  mst_ready_i
);

  // Buffered wide beat.
  dw_chan_pkg::slv_data_t data_q;
  dw_chan_pkg::slv_strb_t strb_q;
  logic                   full_q;

  // Selects which narrow lane group goes out next.
  dw_resp_pkg::beat_sel_t sel_q;

  logic beat_xfer;
  logic last_beat;
  logic take;

  assign beat_xfer = mst_valid_o & mst_ready_i;
  assign last_beat = (sel_q == dw_resp_pkg::beat_sel_t'(`DW_FACTOR - 1));

  // Same buffering rule as the address path. Empty, or emptying now.
  assign slv_ready_o = ~full_q | (beat_xfer & last_beat);
  assign take        = slv_valid_i & slv_ready_o;
  assign mst_valid_o = full_q;

  // Lane select.
  // A half with an all-zero strobe is still sent, which keeps the beat count
  // equal to the address splitter's and the B count predictable.
  assign mst_data_o = data_q[sel_q*`DW_MST_DATA_WIDTH +: `DW_MST_DATA_WIDTH];
  assign mst_strb_o = strb_q[sel_q*`DW_MST_STRB_WIDTH +: `DW_MST_STRB_WIDTH];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      if (take) begin
        full_q <= 1'b1;
      end else if (beat_xfer && last_beat) begin
        full_q <= 1'b0;
      end
      if (beat_xfer) begin
        sel_q <= dw_resp_pkg::beat_sel_t'(sel_q + 1'b1);
      end
    end
  end

  // Wide beat payload, loaded on slave handshake.
  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= slv_data_i;
      strb_q <= slv_strb_i;
    end
  end

  // Under stall the master W beat must not change.
  a_w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_valid_o && !mst_ready_i) |=>
      (mst_valid_o && $stable(mst_data_o) && $stable(mst_strb_o)))
    else $error("Master W beat changed while stalled.");

endmodule

//--- verilog/dw_resp_merger.sv
/*
 * Response merger for the downsizer.
 * Collects the narrow B and R beats and presents one wide B or R
 * response, with the response codes ORed across the beats.
 */
`timescale 1ns/10ps
`include "dw_macros.svh"

module dw_resp_merger (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  dw_resp_pkg::resp_t     mst_b_resp_i,
  input  logic                   mst_b_valid_i,
  output logic                   mst_b_ready_o,
  output dw_resp_pkg::resp_t     slv_b_resp_o,
  output logic                   slv_b_valid_o,
  input  logic                   slv_b_ready_i,
  input  dw_chan_pkg::mst_data_t mst_r_data_i,
  input  dw_resp_pkg::resp_t     mst_r_resp_i,
  input  logic                   mst_r_valid_i,
  output logic                   mst_r_ready_o,
  output dw_chan_pkg::slv_data_t slv_r_data_o,
  output dw_resp_pkg::resp_t     slv_r_resp_o,
  output logic                   slv_r_valid_o,
  input  logic                   slv_r_ready_i
);

  // Write response path.
  dw_resp_pkg::beat_sel_t b_sel_q;
  dw_resp_pkg::resp_t     b_resp_q;
  logic                   b_last;
  logic                   b_xfer;

  // Read response path.
  dw_resp_pkg::beat_sel_t r_sel_q;
  dw_resp_pkg::resp_t     r_resp_q;
  dw_chan_pkg::mst_data_t r_data_q;
  logic                   r_last;
  logic                   r_xfer;

  assign b_last = (b_sel_q == dw_resp_pkg::beat_sel_t'(`DW_FACTOR - 1));
  assign r_last = (r_sel_q == dw_resp_pkg::beat_sel_t'(`DW_FACTOR - 1));

  // Early beats are absorbed at once. The last beat is passed through, so
  // its handshake is tied directly to the slave side.
  assign mst_b_ready_o = b_last ? slv_b_ready_i : 1'b1;
  assign slv_b_valid_o = b_last & mst_b_valid_i;
  assign slv_b_resp_o  = b_resp_q | mst_b_resp_i;
  assign b_xfer        = mst_b_valid_i & mst_b_ready_o;

  assign mst_r_ready_o = r_last ? slv_r_ready_i : 1'b1;
  assign slv_r_valid_o = r_last & mst_r_valid_i;
  assign slv_r_resp_o  = r_resp_q | mst_r_resp_i;
  // The live beat is the upper half, the stored one the lower half.
  assign slv_r_data_o  = {mst_r_data_i, r_data_q};
  assign r_xfer        = mst_r_valid_i & mst_r_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_sel_q  <= '0;
      b_resp_q <= dw_resp_pkg::RESP_OKAY;
      r_sel_q  <= '0;
      r_resp_q <= dw_resp_pkg::RESP_OKAY;
    end else begin
      if (b_xfer) begin
        b_sel_q <= dw_resp_pkg::beat_sel_t'(b_sel_q + 1'b1);
        // Accumulate, then start clean for the next transaction.
        if (b_last) begin
          b_resp_q <= dw_resp_pkg::RESP_OKAY;
        end else begin
          b_resp_q <= b_resp_q | mst_b_resp_i;
        end
      end
      if (r_xfer) begin
        r_sel_q <= dw_resp_pkg::beat_sel_t'(r_sel_q + 1'b1);
        if (!r_last) begin
          r_resp_q <= mst_r_resp_i;
        end
      end
    end
  end

  // Lower read half, captured from beat 0.
  always_ff @(posedge clk_i) begin
    if (r_xfer && !r_last) begin
      r_data_q <= mst_r_data_i;
    end
  end

  // A wide response stalled on the slave side keeps its value until taken.
  a_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_b_valid_o && !slv_b_ready_i) |=> (slv_b_valid_o && $stable(slv_b_resp_o)))
    else $error("Slave B response changed while stalled.");

  a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_r_valid_o && !slv_r_ready_i) |=>
      (slv_r_valid_o && $stable(slv_r_data_o) && $stable(slv_r_resp_o)))
    else $error("Slave R beat changed while stalled.");

endmodule

//--- verilog/dw_downsizer.sv
/*
 * AXI4-Lite 64 to 32 bit downsizer top level.
 * Connects the AW and AR splitters, the W slicer and the
 * B/R merger between the slave and master ports.
 */
`timescale 1ns/10ps

module dw_downsizer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Slave port, 64 bit.
  input  dw_chan_pkg::addr_t     slv_aw_addr_i,
  input  dw_chan_pkg::prot_t     slv_aw_prot_i,
  input  logic                   slv_aw_valid_i,
  output logic                   slv_aw_ready_o,
  input  dw_chan_pkg::slv_data_t slv_w_data_i,
  input  dw_chan_pkg::slv_strb_t slv_w_strb_i,
  input  logic                   slv_w_valid_i,
  output logic                   slv_w_ready_o,
  output dw_resp_pkg::resp_t     slv_b_resp_o,
  output logic                   slv_b_valid_o,
  input  logic                   slv_b_ready_i,
  input  dw_chan_pkg::addr_t     slv_ar_addr_i,
  input  dw_chan_pkg::prot_t     slv_ar_prot_i,
  input  logic                   slv_ar_valid_i,
  output logic                   slv_ar_ready_o,
  output dw_chan_pkg::slv_data_t slv_r_data_o,
  output dw_resp_pkg::resp_t     slv_r_resp_o,
  output logic                   slv_r_valid_o,
  input  logic                   slv_r_ready_i,
  // Master port, 32 bit.
  output dw_chan_pkg::addr_t     mst_aw_addr_o,
  output dw_chan_pkg::prot_t     mst_aw_prot_o,
  output logic                   mst_aw_valid_o,
  input  logic                   mst_aw_ready_i,
  output dw_chan_pkg::mst_data_t mst_w_data_o,
  output dw_chan_pkg::mst_strb_t mst_w_strb_o,
  output logic                   mst_w_valid_o,
  input  logic                   mst_w_ready_i,
  input  dw_resp_pkg::resp_t     mst_b_resp_i,
  input  logic                   mst_b_valid_i,
  output logic                   mst_b_ready_o,
  output dw_chan_pkg::addr_t     mst_ar_addr_o,
  output dw_chan_pkg::prot_t     mst_ar_prot_o,
  output logic                   mst_ar_valid_o,
  input  logic                   mst_ar_ready_i,
  input  dw_chan_pkg::mst_data_t mst_r_data_i,
  input  dw_resp_pkg::resp_t     mst_r_resp_i,
  input  logic                   mst_r_valid_i,
  output logic                   mst_r_ready_o
);

  // Request channels bundled as structs for the splitters.
  dw_chan_pkg::aw_chan_t slv_aw_chan;
  dw_chan_pkg::aw_chan_t mst_aw_chan;
  dw_chan_pkg::ar_chan_t slv_ar_chan;
  dw_chan_pkg::ar_chan_t mst_ar_chan;

  assign slv_aw_chan   = '{addr: slv_aw_addr_i, prot: slv_aw_prot_i};
  assign slv_ar_chan   = '{addr: slv_ar_addr_i, prot: slv_ar_prot_i};
  assign mst_aw_addr_o = mst_aw_chan.addr;
  assign mst_aw_prot_o = mst_aw_chan.prot;
  assign mst_ar_addr_o = mst_ar_chan.addr;
  assign mst_ar_prot_o = mst_ar_chan.prot;

  // Write address, one wide request into two beat addresses.
  dw_addr_splitter #(
    .chan_t (dw_chan_pkg::aw_chan_t)
  ) u_aw_splitter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .chan_i  (slv_aw_chan),
    .valid_i (slv_aw_valid_i),
    .ready_o (slv_aw_ready_o),
    .chan_o  (mst_aw_chan),
    .valid_o (mst_aw_valid_o),
    .ready_i (mst_aw_ready_i)
  );

  // Read address, same splitting.
  dw_addr_splitter #(
    .chan_t (dw_chan_pkg::ar_chan_t)
  ) u_ar_splitter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .chan_i  (slv_ar_chan),
    .valid_i (slv_ar_valid_i),
    .ready_o (slv_ar_ready_o),
    .chan_o  (mst_ar_chan),
    .valid_o (mst_ar_valid_o),
    .ready_i (mst_ar_ready_i)
  );

  // Write data lanes.
  dw_wdata_slicer u_wdata_slicer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_data_i  (slv_w_data_i),
    .slv_strb_i  (slv_w_strb_i),
    .slv_valid_i (slv_w_valid_i),
    .slv_ready_o (slv_w_ready_o),
    .mst_data_o  (mst_w_data_o),
    .mst_strb_o  (mst_w_strb_o),
    .mst_valid_o (mst_w_valid_o),
    .mst_ready_i (mst_w_ready_i)
  );

  // B and R recombination.
  dw_resp_merger u_resp_merger (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_resp_o  (slv_b_resp_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_resp_i  (mst_r_resp_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i)
  );

endmodule

//--- tb/tb_clock_gen.sv
/*
 * Clock and reset source for the downsizer testbench.
 * 4 ns clock and a synchronous active-high reset for 10 cycles.
 */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // Half of the 4 ns period.
  localparam int HALF_PERIOD = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // Reset is released on the tenth rising edge, so the DUT sees it for 10 cycles.
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- tb/dw_downsizer_tb.sv
/*
 * Testbench for the AXI4-Lite 64 to 32 bit downsizer.
 * Memory model on the master port with random ready stalls,
 * directed tests for writes, strobes, read assembly, error merging
 * and back-pressure, a cycle-count timeout and the final report.
 */
`timescale 1ns/10ps
`include "dw_macros.svh"

module dw_downsizer_tb;

  // Reset and the directed tests need about 200 cycles.
  // One random write/read pair under stall takes about 20 cycles and well under 80,
  // so 40 pairs stay far below the limit.
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RANDOM_PAIRS = 40;
  localparam dw_chan_pkg::addr_t ERR_ADDR = 16'h0104;
  localparam int MEM_WORDS = 1 << (`DW_ADDR_WIDTH - `DW_SEL_OFFSET);

  logic                   clk_i;
  logic                   reset_i;
  // Slave port of the DUT.
  dw_chan_pkg::addr_t     slv_aw_addr_i;
  dw_chan_pkg::prot_t     slv_aw_prot_i;
  logic                   slv_aw_valid_i;
  logic                   slv_aw_ready_o;
  dw_chan_pkg::slv_data_t slv_w_data_i;
  dw_chan_pkg::slv_strb_t slv_w_strb_i;
  logic                   slv_w_valid_i;
  logic                   slv_w_ready_o;
  dw_resp_pkg::resp_t     slv_b_resp_o;
  logic                   slv_b_valid_o;
  logic                   slv_b_ready_i;
  dw_chan_pkg::addr_t     slv_ar_addr_i;
  dw_chan_pkg::prot_t     slv_ar_prot_i;
  logic                   slv_ar_valid_i;
  logic                   slv_ar_ready_o;
  dw_chan_pkg::slv_data_t slv_r_data_o;
  dw_resp_pkg::resp_t     slv_r_resp_o;
  logic                   slv_r_valid_o;
  logic                   slv_r_ready_i;
  // Master port of the DUT.
  dw_chan_pkg::addr_t     mst_aw_addr_o;
  dw_chan_pkg::prot_t     mst_aw_prot_o;
  logic                   mst_aw_valid_o;
  logic                   mst_aw_ready_i;
  dw_chan_pkg::mst_data_t mst_w_data_o;
  dw_chan_pkg::mst_strb_t mst_w_strb_o;
  logic                   mst_w_valid_o;
  logic                   mst_w_ready_i;
  dw_resp_pkg::resp_t     mst_b_resp_i;
  logic                   mst_b_valid_i;
  logic                   mst_b_ready_o;
  dw_chan_pkg::addr_t     mst_ar_addr_o;
  dw_chan_pkg::prot_t     mst_ar_prot_o;
  logic                   mst_ar_valid_o;
  logic                   mst_ar_ready_i;
  dw_chan_pkg::mst_data_t mst_r_data_i;
  dw_resp_pkg::resp_t     mst_r_resp_i;
  logic                   mst_r_valid_i;
  logic                   mst_r_ready_o;

  // Memory model state. Each queue holds accepted beats not yet answered.
  dw_chan_pkg::mst_data_t mem [0:MEM_WORDS-1];
  dw_chan_pkg::addr_t     aw_q[$];
  dw_chan_pkg::prot_t     aw_prot_q[$];
  dw_chan_pkg::mst_data_t wd_q[$];
  dw_chan_pkg::mst_strb_t ws_q[$];
  dw_resp_pkg::resp_t     b_q[$];
  dw_chan_pkg::mst_data_t rd_q[$];
  dw_resp_pkg::resp_t     rr_q[$];
  // Master beats in the order the model accepted them.
  dw_chan_pkg::addr_t     log_addr[$];
  dw_chan_pkg::prot_t     log_prot[$];
  dw_chan_pkg::mst_data_t log_data[$];
  dw_chan_pkg::mst_strb_t log_strb[$];
  dw_chan_pkg::addr_t     ar_log[$];
  dw_chan_pkg::prot_t     ar_prot_log[$];

  integer seed = 37;
  logic   stall_en = 1'b0;
  int     mismatch_cnt = 0;
  int     fail_cnt = 0;
  int     cycle_cnt;

  tb_clock_gen clock_gen_inst (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  dw_downsizer dw_downsizer_inst (.*);

  // While stalling, a ready is high in about three cycles out of four.
  function automatic logic draw_ready();
    logic [31:0] r;
    r = $random(seed);
    return !stall_en || (r[1:0] != 2'b00);
  endfunction

  // The model answers the error word with SLVERR and all other words with OKAY.
  function automatic dw_resp_pkg::resp_t model_resp(input dw_chan_pkg::addr_t a);
    return (a == ERR_ADDR) ? dw_resp_pkg::RESP_SLVERR : dw_resp_pkg::RESP_OKAY;
  endfunction

  // Beat b of a wide access is the word-aligned address with select bit b.
  function automatic dw_chan_pkg::addr_t beat_addr(input dw_chan_pkg::addr_t a, input logic b);
    return {a[15:3], b, 2'b00};
  endfunction

  // The wide response is the OR of both beat responses.
  function automatic dw_resp_pkg::resp_t expected_resp(input dw_chan_pkg::addr_t a);
    return model_resp(beat_addr(a, 1'b0)) | model_resp(beat_addr(a, 1'b1));
  endfunction

  // Readies of the master port and of the slave B and R channels.
  initial begin
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_ar_ready_i = 1'b1;
    slv_b_ready_i  = 1'b1;
    slv_r_ready_i  = 1'b1;
    forever begin
      @(posedge clk_i);
      mst_aw_ready_i <= draw_ready();
      mst_w_ready_i  <= draw_ready();
      mst_ar_ready_i <= draw_ready();
      slv_b_ready_i  <= draw_ready();
      slv_r_ready_i  <= draw_ready();
    end
  end

  // Master-port memory model.
  initial begin
    dw_chan_pkg::addr_t     waddr;
    dw_chan_pkg::prot_t     wprot;
    dw_chan_pkg::mst_data_t wdata;
    dw_chan_pkg::mst_strb_t wstrb;
    // Every word starts out holding a tag and its own byte address.
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'hC0DE, i[13:0], 2'b00};
    end
    mst_b_valid_i = 1'b0;
    mst_b_resp_i  = dw_resp_pkg::RESP_OKAY;
    mst_r_valid_i = 1'b0;
    mst_r_data_i  = '0;
    mst_r_resp_i  = dw_resp_pkg::RESP_OKAY;
    forever begin
      @(posedge clk_i);
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        aw_q.push_back(mst_aw_addr_o);
        aw_prot_q.push_back(mst_aw_prot_o);
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        wd_q.push_back(mst_w_data_o);
        ws_q.push_back(mst_w_strb_o);
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        void'(b_q.pop_front());
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        void'(rd_q.pop_front());
        void'(rr_q.pop_front());
      end
      // A write completes once its address and its data have both arrived.
      while (aw_q.size() > 0 && wd_q.size() > 0) begin
        waddr = aw_q.pop_front();
        wprot = aw_prot_q.pop_front();
        wdata = wd_q.pop_front();
        wstrb = ws_q.pop_front();
        log_addr.push_back(waddr);
        log_prot.push_back(wprot);
        log_data.push_back(wdata);
        log_strb.push_back(wstrb);
        if (waddr != ERR_ADDR) begin
          for (int k = 0; k < 4; k++) begin
            if (wstrb[k]) begin
              mem[waddr[15:2]][8*k +: 8] = wdata[8*k +: 8];
            end
          end
        end
        b_q.push_back(model_resp(waddr));
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        ar_log.push_back(mst_ar_addr_o);
        ar_prot_log.push_back(mst_ar_prot_o);
        rd_q.push_back(mem[mst_ar_addr_o[15:2]]);
        rr_q.push_back(model_resp(mst_ar_addr_o));
      end
      // The head of each response queue stays on the bus until it is taken.
      mst_b_valid_i <= (b_q.size() > 0);
      if (b_q.size() > 0) begin
        mst_b_resp_i <= b_q[0];
      end
      mst_r_valid_i <= (rd_q.size() > 0);
      if (rd_q.size() > 0) begin
        mst_r_data_i <= rd_q[0];
        mst_r_resp_i <= rr_q[0];
      end
    end
  end

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
    end
  endtask

  // Checks the two master W beats logged from index base on.
  task automatic check_write_beats(input string test, input int base,
                                   input dw_chan_pkg::addr_t addr,
                                   input dw_chan_pkg::prot_t prot,
                                   input dw_chan_pkg::slv_data_t data,
                                   input dw_chan_pkg::slv_strb_t strb);
    if (log_addr.size() != base + 2) begin
      fail_cnt++;
      $display("ERROR: %s expected two master write beats but the model logged %0d",
               test, log_addr.size() - base);
    end else begin
      check_value(test, "beat 0 addr", 64'(beat_addr(addr, 1'b0)), 64'(log_addr[base]));
      check_value(test, "beat 0 prot", 64'(prot), 64'(log_prot[base]));
      check_value(test, "beat 0 data", 64'(data[31:0]), 64'(log_data[base]));
      check_value(test, "beat 0 strb", 64'(strb[3:0]), 64'(log_strb[base]));
      check_value(test, "beat 1 addr", 64'(beat_addr(addr, 1'b1)), 64'(log_addr[base+1]));
      check_value(test, "beat 1 prot", 64'(prot), 64'(log_prot[base+1]));
      check_value(test, "beat 1 data", 64'(data[63:32]), 64'(log_data[base+1]));
      check_value(test, "beat 1 strb", 64'(strb[7:4]), 64'(log_strb[base+1]));
    end
  endtask

  task automatic check_read_beats(input string test, input int base,
                                  input dw_chan_pkg::addr_t addr,
                                  input dw_chan_pkg::prot_t prot);
    if (ar_log.size() != base + 2) begin
      fail_cnt++;
      $display("ERROR: %s expected two master read beats but the model logged %0d",
               test, ar_log.size() - base);
    end else begin
      check_value(test, "ar beat 0", 64'(beat_addr(addr, 1'b0)), 64'(ar_log[base]));
      check_value(test, "ar beat 0 prot", 64'(prot), 64'(ar_prot_log[base]));
      check_value(test, "ar beat 1", 64'(beat_addr(addr, 1'b1)), 64'(ar_log[base+1]));
      check_value(test, "ar beat 1 prot", 64'(prot), 64'(ar_prot_log[base+1]));
    end
  endtask

  // One wide write. AW and W are offered together and B is awaited.
  task automatic write_wide(input dw_chan_pkg::addr_t addr, input dw_chan_pkg::slv_data_t data,
                            input dw_chan_pkg::slv_strb_t strb,
                            input dw_chan_pkg::prot_t prot,
                            output dw_resp_pkg::resp_t resp);
    logic aw_done;
    logic w_done;
    logic b_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    @(posedge clk_i);
    slv_aw_addr_i  <= addr;
    slv_aw_prot_i  <= prot;
    slv_aw_valid_i <= 1'b1;
    slv_w_data_i   <= data;
    slv_w_strb_i   <= strb;
    slv_w_valid_i  <= 1'b1;
    while (!b_done) begin
      @(posedge clk_i);
      if (!aw_done && slv_aw_ready_o) begin
        aw_done = 1'b1;
        slv_aw_valid_i <= 1'b0;
      end
      if (!w_done && slv_w_ready_o) begin
        w_done = 1'b1;
        slv_w_valid_i <= 1'b0;
      end
      if (slv_b_valid_o && slv_b_ready_i) begin
        b_done = 1'b1;
        resp = slv_b_resp_o;
      end
    end
  endtask

  task automatic read_wide(input dw_chan_pkg::addr_t addr,
                           input dw_chan_pkg::prot_t prot,
                           output dw_chan_pkg::slv_data_t data,
                           output dw_resp_pkg::resp_t resp);
    logic ar_done;
    logic r_done;
    ar_done = 1'b0;
    r_done  = 1'b0;
    @(posedge clk_i);
    slv_ar_addr_i  <= addr;
    slv_ar_prot_i  <= prot;
    slv_ar_valid_i <= 1'b1;
    while (!r_done) begin
      @(posedge clk_i);
      if (!ar_done && slv_ar_ready_o) begin
        ar_done = 1'b1;
        slv_ar_valid_i <= 1'b0;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        r_done = 1'b1;
        data = slv_r_data_o;
        resp = slv_r_resp_o;
      end
    end
  endtask

  task automatic full_write_test();
    dw_resp_pkg::resp_t resp;
    int                 base;
    base = log_addr.size();
    write_wide(16'h0010, 64'hBEEFBEEF_AAAABBBB, 8'hFF, 3'h5, resp);
    check_value("full_write", "b resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
    check_write_beats("full_write", base, 16'h0010, 3'h5, 64'hBEEFBEEF_AAAABBBB, 8'hFF);
  endtask

  // The lower half has no strobe bits set and must still go out as a beat.
  task automatic partial_strobe_test();
    dw_resp_pkg::resp_t resp;
    int                 base;
    base = log_addr.size();
    write_wide(16'h0024, 64'h12345678_9ABCDEF0, 8'hF0, 3'h2, resp);
    check_value("partial_strobe", "b resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
    check_write_beats("partial_strobe", base, 16'h0024, 3'h2, 64'h12345678_9ABCDEF0, 8'hF0);
  endtask

  task automatic read_assembly_test();
    dw_resp_pkg::resp_t     resp;
    dw_chan_pkg::slv_data_t rdata;
    int                     base;
    // Each write fills one of the two words, so the read must merge both.
    write_wide(16'h0040, 64'hFFFFFFFF_11110040, 8'h0F, 3'h0, resp);
    write_wide(16'h0044, 64'h22220044_FFFFFFFF, 8'hF0, 3'h0, resp);
    base = ar_log.size();
    read_wide(16'h0040, 3'h6, rdata, resp);
    check_value("read_assembly", "r resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
    check_value("read_assembly", "r data", 64'h22220044_11110040, rdata);
    check_read_beats("read_assembly", base, 16'h0040, 3'h6);
  endtask

  task automatic error_aggregation_test();
    dw_resp_pkg::resp_t     resp;
    dw_chan_pkg::slv_data_t rdata;
    write_wide(16'h0100, 64'h0BAD0BAD_0BAD0BAD, 8'hFF, 3'h1, resp);
    check_value("error_aggregation", "b resp", 64'(expected_resp(16'h0100)), 64'(resp));
    read_wide(16'h0100, 3'h1, rdata, resp);
    check_value("error_aggregation", "r resp", 64'(expected_resp(16'h0100)), 64'(resp));
    // A clean access afterwards shows that no error is carried over.
    write_wide(16'h0200, 64'h600D600D_00000200, 8'hFF, 3'h1, resp);
    check_value("error_aggregation", "clean b resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
    read_wide(16'h0200, 3'h1, rdata, resp);
    check_value("error_aggregation", "clean r resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
    check_value("error_aggregation", "clean r data", 64'h600D600D_00000200, rdata);
  endtask

  task automatic back_pressure_test();
    dw_resp_pkg::resp_t     resp;
    dw_chan_pkg::slv_data_t wdata;
    dw_chan_pkg::slv_data_t rdata;
    dw_chan_pkg::addr_t     addr;
    dw_chan_pkg::prot_t     wprot;
    dw_chan_pkg::prot_t     rprot;
    logic [31:0]            rnd;
    int                     wbase;
    int                     rbase;
    stall_en = 1'b1;
    for (int n = 0; n < RANDOM_PAIRS; n++) begin
      rnd = $random(seed);
      addr = rnd[15:0];
      wprot = rnd[18:16];
      rprot = rnd[21:19];
      // Stay clear of the error word so that every pair must succeed.
      if (expected_resp(addr) != dw_resp_pkg::RESP_OKAY) begin
        addr = addr ^ 16'h0800;
      end
      wdata[63:32] = $random(seed);
      wdata[31:0]  = $random(seed);
      wbase = log_addr.size();
      write_wide(addr, wdata, 8'hFF, wprot, resp);
      check_value("back_pressure", "b resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
      check_write_beats("back_pressure", wbase, addr, wprot, wdata, 8'hFF);
      rbase = ar_log.size();
      read_wide(addr, rprot, rdata, resp);
      check_value("back_pressure", "r resp", 64'(dw_resp_pkg::RESP_OKAY), 64'(resp));
      check_value("back_pressure", "r data", wdata, rdata);
      check_read_beats("back_pressure", rbase, addr, rprot);
    end
    stall_en = 1'b0;
  endtask

  initial begin
    slv_aw_addr_i  = '0;
    slv_aw_prot_i  = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_ar_addr_i  = '0;
    slv_ar_prot_i  = '0;
    slv_ar_valid_i = 1'b0;
    @(posedge clk_i);
    while (reset_i) begin
      @(posedge clk_i);
    end
    full_write_test();
    partial_strobe_test();
    read_assembly_test();
    error_aggregation_test();
    back_pressure_test();
    repeat (5) @(posedge clk_i);
    report_counts();
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog. A stuck handshake ends the run here.
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    fail_cnt++;
    $display("ERROR: timeout after %0d cycles, a handshake never completed", cycle_cnt);
    report_counts();
    $display("Verification failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/dw_chan_pkg.sv
verilog/dw_resp_pkg.sv
verilog/dw_addr_splitter.sv
verilog/dw_wdata_slicer.sv
verilog/dw_resp_merger.sv
verilog/dw_downsizer.sv
tb/tb_clock_gen.sv
tb/dw_downsizer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the downsizer testbench with Verilator and runs it.
# Exits non-zero if the build or the run fails, or if the log
# reports a failed verification.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f src.f \
  --top-module dw_downsizer_tb --Mdir "$OBJ" -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
